/* sources.f */
design/ps2_pkg.sv
design/ps2_line_sync.sv
design/ps2_frame_rx.sv
design/key_event_decoder.sv
design/key_event_fifo.sv
design/kbd_axil_regs.sv
design/kbd_ctrl_top.sv
tests/kbd_ctrl_tb.sv

/* tests/kbd_ctrl_tb.sv */
`timescale 1ns/1ps

module kbd_ctrl_tb;

    localparam int FIFO_DEPTH     = 4;
    localparam int TIMEOUT_CYCLES = 64;
    localparam int HALF_BIT       = 8;
    localparam int WAIT_LIMIT     = 500;

    logic               PS2_clk;
    logic               rst_n;
    logic               kbd_clk;
    logic               kbd_data;
    logic               kbd_clk_oe;
    ps2_pkg::axil_req_t axil_req;
    ps2_pkg::axil_rsp_t axil_rsp;

    int          value_errs;
    int          bus_errs;
    int          timeouts;
    logic [7:0]  codes [6];
    logic [31:0] rd_data;
    logic [1:0]  resp;

    kbd_ctrl_top #(
        .FIFO_DEPTH     (FIFO_DEPTH),
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) DUT (
        .PS2_clk    (PS2_clk),
        .rst_n      (rst_n),
        .kbd_clk    (kbd_clk),
        .kbd_data   (kbd_data),
        .kbd_clk_oe (kbd_clk_oe),
        .axil_req   (axil_req),
        .axil_rsp   (axil_rsp)
    );

    initial begin
        PS2_clk = 1'b0;
        forever #50 PS2_clk = ~PS2_clk;
    end

    a_bvalid_hold: assert property (@(posedge PS2_clk) disable iff (!rst_n)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
        else begin
            bus_errs++;
            $display("write response was dropped before the master took it");
        end

    a_rvalid_hold: assert property (@(posedge PS2_clk) disable iff (!rst_n)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
        else begin
            bus_errs++;
            $display("read response was dropped before the master took it");
        end

    a_arready_valid: assert property (@(posedge PS2_clk) disable iff (!rst_n)
        axil_rsp.arready |-> axil_req.arvalid)
        else begin
            bus_errs++;
            $display("read address was accepted without arvalid");
        end

    a_awready_valid: assert property (@(posedge PS2_clk) disable iff (!rst_n)
        axil_rsp.awready |-> axil_req.awvalid && axil_req.wvalid)
        else begin
            bus_errs++;
            $display("write was accepted without both awvalid and wvalid");
        end

    // Waits n rising edges and lands just after the last one.
    task automatic tick(input int n = 1);
        repeat (n) @(posedge PS2_clk);
        #10;
    endtask

    task automatic finish_run();
        $display("errors: value %0d, bus %0d, timeout %0d", value_errs, bus_errs, timeouts);
        if (value_errs + bus_errs + timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    task automatic give_up(input string what);
        timeouts++;
        $display("timeout: %s", what);
        finish_run();
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            value_errs++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // Expected DATA word with valid in bit 31 above released, extended and code.
    function automatic logic [31:0] data_word(input logic [7:0] code, input bit ext,
                                              input bit rel);
        return {1'b1, 21'd0, rel, ext, code};
    endfunction

    function automatic logic [31:0] status_word(input int count, input bit ovf,
                                                input bit par, input bit fr);
        return {16'd0, 8'(count), 4'd0, fr, par, ovf, count != 0};
    endfunction

    // Ready and valid are sampled at the falling edge.
    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic [1:0] resp_out);
        int   n;
        logic done;
        axil_req.awaddr  = addr;
        axil_req.awvalid = 1'b1;
        axil_req.wdata   = data;
        axil_req.wstrb   = 4'hF;
        axil_req.wvalid  = 1'b1;
        axil_req.bready  = 1'b0;
        n = 0;
        do begin
            @(negedge PS2_clk);
            done = axil_rsp.awready && axil_rsp.wready;
            tick();
            n++;
        end while (!done && n < WAIT_LIMIT);
        if (!done) give_up("write address and data were never accepted");
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        n = 0;
        do begin
            @(negedge PS2_clk);
            done = axil_rsp.bvalid;
            tick();
            n++;
        end while (!done && n < WAIT_LIMIT);
        if (!done) give_up("write response never arrived");
        // The response waits a cycle with bready low before it is taken.
        axil_req.bready = 1'b1;
        @(negedge PS2_clk);
        resp_out = axil_rsp.bresp;
        tick();
        axil_req.bready = 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic [1:0] resp_out);
        int   n;
        logic done;
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        axil_req.rready  = 1'b0;
        n = 0;
        do begin
            @(negedge PS2_clk);
            done = axil_rsp.arready;
            tick();
            n++;
        end while (!done && n < WAIT_LIMIT);
        if (!done) give_up("read address was never accepted");
        axil_req.arvalid = 1'b0;
        n = 0;
        do begin
            @(negedge PS2_clk);
            done = axil_rsp.rvalid;
            tick();
            n++;
        end while (!done && n < WAIT_LIMIT);
        if (!done) give_up("read data never arrived");
        // Read data also waits a cycle with rready low.
        axil_req.rready = 1'b1;
        @(negedge PS2_clk);
        data     = axil_rsp.rdata;
        resp_out = axil_rsp.rresp;
        tick();
        axil_req.rready = 1'b0;
    endtask

    task automatic read_check(input string name, input logic [3:0] addr,
                              input logic [31:0] exp);
        logic [31:0] data;
        logic [1:0]  rsp;
        axi_read(addr, data, rsp);
        check_value({name, " resp"}, ps2_pkg::RESP_OKAY, rsp);
        check_value(name, exp, data);
    endtask

    task automatic poll_status(input logic [31:0] mask, input logic [31:0] value,
                               input string what);
        logic [31:0] data;
        logic [1:0]  rsp;
        int          n;
        n = 0;
        do begin
            axi_read(ps2_pkg::REG_STATUS, data, rsp);
            n++;
        end while ((data & mask) != value && n < WAIT_LIMIT);
        if ((data & mask) != value) give_up(what);
    endtask

    // Keyboard model. Data changes while the clock is high and the host samples on the fall.
    task automatic send_frame(input logic [7:0] code, input bit bad_par = 1'b0,
                              input bit bad_start = 1'b0, input bit bad_stop = 1'b0,
                              input int nbits = 11);
        logic [10:0] frame;
        int          i;
        frame[0]   = bad_start;
        frame[8:1] = code;
        frame[9]   = (~^code) ^ bad_par;
        frame[10]  = !bad_stop;
        for (i = 0; i < nbits; i++) begin
            kbd_data = frame[i];
            tick(HALF_BIT);
            kbd_clk = 1'b0;
            tick(HALF_BIT);
            kbd_clk = 1'b1;
        end
        tick(HALF_BIT);
        kbd_data = 1'b1;
        tick(2 * HALF_BIT);
    endtask

    initial begin
        logic [7:0] c;
        int         i;
        void'($urandom(32'h63e2_25f5));
        value_errs = 0;
        bus_errs   = 0;
        timeouts   = 0;
        rst_n      = 1'b0;
        kbd_clk    = 1'b1;
        kbd_data   = 1'b1;
        axil_req   = '0;
        tick(3);
        rst_n = 1'b1;
        tick();

        check_value("reset oe", 32'd1, kbd_clk_oe);
        read_check("reset status", ps2_pkg::REG_STATUS, 32'h0);
        read_check("reset ctrl", ps2_pkg::REG_CTRL, 32'h0);
        axi_write(ps2_pkg::REG_CTRL, 32'h1, resp);
        check_value("enable resp", ps2_pkg::RESP_OKAY, resp);
        check_value("enable oe", 32'd0, kbd_clk_oe);

        send_frame(8'h1C);
        send_frame(8'hF0);
        send_frame(8'h1C);
        send_frame(8'hE0);
        send_frame(8'h75);
        send_frame(8'hE0);
        send_frame(8'hF0);
        send_frame(8'h75);
        poll_status(32'h0000_FF00, 32'h0000_0400, "four key events never queued");
        read_check("make 1C", ps2_pkg::REG_DATA, data_word(8'h1C, 1'b0, 1'b0));
        read_check("break 1C", ps2_pkg::REG_DATA, data_word(8'h1C, 1'b0, 1'b1));
        read_check("make E0 75", ps2_pkg::REG_DATA, data_word(8'h75, 1'b1, 1'b0));
        read_check("break E0 75", ps2_pkg::REG_DATA, data_word(8'h75, 1'b1, 1'b1));
        read_check("status drained", ps2_pkg::REG_STATUS, 32'h0);

        send_frame(8'h1C, 1'b1);
        poll_status(32'h4, 32'h4, "parity error flag never set");
        read_check("parity status", ps2_pkg::REG_STATUS, status_word(0, 0, 1, 0));
        read_check("parity errcnt", ps2_pkg::REG_ERRCNT, 32'd1);
        send_frame(8'h1C, 1'b0, 1'b0, 1'b1);
        poll_status(32'h8, 32'h8, "framing error flag never set");
        read_check("stop status", ps2_pkg::REG_STATUS, status_word(0, 0, 1, 1));
        read_check("stop errcnt", ps2_pkg::REG_ERRCNT, 32'd2);
        axi_write(ps2_pkg::REG_CTRL, 32'h3, resp);
        check_value("clear resp", ps2_pkg::RESP_OKAY, resp);
        read_check("cleared status", ps2_pkg::REG_STATUS, 32'h0);
        read_check("cleared errcnt", ps2_pkg::REG_ERRCNT, 32'd0);

        // Prefix bytes would fold into the next code.
        for (i = 0; i < 6; i++) begin
            do begin
                c = 8'($urandom);
            end while (c == 8'hE0 || c == 8'hF0 || c == 8'hE1);
            codes[i] = c;
            send_frame(c);
        end
        poll_status(32'h2, 32'h2, "overflow flag never set");
        read_check("overflow status", ps2_pkg::REG_STATUS, status_word(4, 1, 0, 0));
        for (i = 0; i < 4; i++) begin
            read_check($sformatf("overflow code %0d", i), ps2_pkg::REG_DATA,
                       data_word(codes[i], 1'b0, 1'b0));
        end
        axi_write(ps2_pkg::REG_CTRL, 32'h3, resp);
        read_check("overflow cleared", ps2_pkg::REG_STATUS, 32'h0);

        axi_read(4'h1, rd_data, resp);
        check_value("unmapped read resp", ps2_pkg::RESP_SLVERR, resp);
        axi_write(4'h9, 32'h0, resp);
        check_value("unmapped write resp", ps2_pkg::RESP_SLVERR, resp);
        read_check("ctrl after unmapped write", ps2_pkg::REG_CTRL, 32'h1);
        read_check("status after unmapped write", ps2_pkg::REG_STATUS, 32'h0);
        read_check("empty data read", ps2_pkg::REG_DATA, 32'h0);

        // Start bit and four data bits followed by silence.
        send_frame(8'h5A, 1'b0, 1'b0, 1'b0, 5);
        poll_status(32'h8, 32'h8, "stalled frame never timed out");
        read_check("timeout status", ps2_pkg::REG_STATUS, status_word(0, 0, 0, 1));
        send_frame(8'h2B);
        poll_status(32'h1, 32'h1, "frame after timeout never queued");
        read_check("frame after timeout", ps2_pkg::REG_DATA, data_word(8'h2B, 1'b0, 1'b0));

        finish_run();
    end

endmodule

/* design/kbd_ctrl_top.sv */
`timescale 1ns/1ps

module kbd_ctrl_top #(
    parameter int FIFO_DEPTH     = 16,
    parameter int TIMEOUT_CYCLES = 20000
) (
    input  logic               PS2_clk,
    input  logic               rst_n,
    input  logic               kbd_clk,
    input  logic               kbd_data,
    output logic               kbd_clk_oe,
    input  ps2_pkg::axil_req_t axil_req,
    output ps2_pkg::axil_rsp_t axil_rsp
);

    localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;

    logic                fall_pulse;
    logic                data_bit;
    logic [7:0]          rx_byte;
    logic                byte_valid;
    ps2_pkg::rx_err_t    rx_err;
    logic                err_valid;
    ps2_pkg::key_event_t ev;
    logic                ev_valid;
    ps2_pkg::key_event_t head;
    logic                empty;
    logic [CNT_W-1:0]    count;
    logic                overflow;
    logic                pop;
    logic                clear_overflow;
    logic                enable;

    ps2_line_sync u_line_sync (
        .PS2_clk    (PS2_clk),
        .rst_n      (rst_n),
        .kbd_clk    (kbd_clk),
        .kbd_data   (kbd_data),
        .fall_pulse (fall_pulse),
        .data_bit   (data_bit)
    );

    ps2_frame_rx #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) u_frame_rx (
        .PS2_clk    (PS2_clk),
        .rst_n      (rst_n),
        .enable     (enable),
        .fall_pulse (fall_pulse),
        .data_bit   (data_bit),
        .byte_out   (rx_byte),
        .byte_valid (byte_valid),
        .err        (rx_err),
        .err_valid  (err_valid)
    );

    key_event_decoder u_decoder (
        .PS2_clk    (PS2_clk),
        .rst_n      (rst_n),
        .byte_in    (rx_byte),
        .byte_valid (byte_valid),
        .ev         (ev),
        .ev_valid   (ev_valid)
    );

    key_event_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .PS2_clk        (PS2_clk),
        .rst_n          (rst_n),
        .push           (ev_valid),
        .push_ev        (ev),
        .pop            (pop),
        .head           (head),
        .empty          (empty),
        .count          (count),
        .overflow       (overflow),
        .clear_overflow (clear_overflow)
    );

    kbd_axil_regs #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_regs (
        .PS2_clk        (PS2_clk),
        .rst_n          (rst_n),
        .axil_req       (axil_req),
        .axil_rsp       (axil_rsp),
        .head           (head),
        .empty          (empty),
        .count          (count),
        .overflow       (overflow),
        .err            (rx_err),
        .err_valid      (err_valid),
        .pop            (pop),
        .clear_overflow (clear_overflow),
        .enable         (enable),
        .kbd_clk_oe     (kbd_clk_oe)
    );

endmodule

/* design/kbd_axil_regs.sv */
`timescale 1ns/1ps

module kbd_axil_regs #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                         PS2_clk,
    input  logic                         rst_n,
    input  ps2_pkg::axil_req_t           axil_req,
    output ps2_pkg::axil_rsp_t           axil_rsp,
    input  ps2_pkg::key_event_t          head,
    input  logic                         empty,
    input  logic [$clog2(FIFO_DEPTH):0]  count,
    input  logic                         overflow,
    input  ps2_pkg::rx_err_t             err,
    input  logic                         err_valid,
    output logic                         pop,
    output logic                         clear_overflow,
    output logic                         enable,
    output logic                         kbd_clk_oe
);

    logic                            wr_hs;
    logic                            rd_hs;
    logic                            ctrl_wr;
    logic                            bvalid;
    logic                            rvalid;
    ps2_pkg::axil_resp_e             bresp;
    ps2_pkg::axil_resp_e             rresp;
    logic [ps2_pkg::AXIL_DATA_W-1:0] rdata;
    logic [ps2_pkg::AXIL_DATA_W-1:0] rd_mux;
    ps2_pkg::axil_resp_e             rd_resp;
    logic                            sticky_par;
    logic                            sticky_fr;
    logic [7:0]                      err_cnt;

    // AW and W are taken together, one response in flight per channel.
    assign wr_hs   = axil_req.awvalid && axil_req.wvalid && !bvalid;
    assign rd_hs   = axil_req.arvalid && !rvalid;
    assign ctrl_wr = wr_hs && (axil_req.awaddr == ps2_pkg::REG_CTRL) && axil_req.wstrb[0];

    assign clear_overflow = ctrl_wr && axil_req.wdata[1];
    assign pop            = rd_hs && (axil_req.araddr == ps2_pkg::REG_DATA) && !empty;
    assign kbd_clk_oe     = !enable;

    always_comb begin
        rd_mux  = '0;
        rd_resp = ps2_pkg::RESP_OKAY;
        case (ps2_pkg::reg_addr_e'(axil_req.araddr))
            ps2_pkg::REG_STATUS: begin
                rd_mux[0]    = !empty;
                rd_mux[1]    = overflow;
                rd_mux[2]    = sticky_par;
                rd_mux[3]    = sticky_fr;
                rd_mux[15:8] = 8'(count);
            end
            ps2_pkg::REG_DATA: begin
                if (!empty) begin
                    rd_mux[9:0] = head;
                    rd_mux[31]  = 1'b1;
                end
            end
            ps2_pkg::REG_CTRL:   rd_mux[0] = enable;
            ps2_pkg::REG_ERRCNT: rd_mux[7:0] = err_cnt;
            default:             rd_resp = ps2_pkg::RESP_SLVERR;
        endcase
    end

    always_ff @(posedge PS2_clk) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            enable <= 1'b0;
        end else begin
            if (wr_hs) begin
                bvalid <= 1'b1;
                case (ps2_pkg::reg_addr_e'(axil_req.awaddr))
                    ps2_pkg::REG_STATUS, ps2_pkg::REG_DATA, ps2_pkg::REG_ERRCNT:
                        bresp <= ps2_pkg::RESP_OKAY;
                    ps2_pkg::REG_CTRL: begin
                        bresp <= ps2_pkg::RESP_OKAY;
                        if (axil_req.wstrb[0]) begin
                            enable <= axil_req.wdata[0];
                        end
                    end
                    default: bresp <= ps2_pkg::RESP_SLVERR;
                endcase
            end else if (axil_req.bready) begin
                bvalid <= 1'b0;
            end
            if (rd_hs) begin
                rvalid <= 1'b1;
                rdata  <= rd_mux;
                rresp  <= rd_resp;
            end else if (axil_req.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge PS2_clk) begin
        if (!rst_n) begin
            sticky_par <= 1'b0;
            sticky_fr  <= 1'b0;
            err_cnt    <= 8'd0;
        end else begin
            if (clear_overflow) begin
                sticky_par <= 1'b0;
                sticky_fr  <= 1'b0;
                err_cnt    <= 8'd0;
            end
            if (err_valid) begin
                sticky_par <= (sticky_par && !clear_overflow) || err.parity;
                sticky_fr  <= (sticky_fr && !clear_overflow) || err.framing;
                if (clear_overflow) begin
                    err_cnt <= 8'd1;
                end else if (err_cnt != 8'hFF) begin
                    err_cnt <= err_cnt + 8'd1;
                end
            end
        end
    end

    assign axil_rsp = '{
        awready: wr_hs,
        wready:  wr_hs,
        bresp:   bresp,
        bvalid:  bvalid,
        arready: rd_hs,
        rdata:   rdata,
        rresp:   rresp,
        rvalid:  rvalid
    };

    a_bvalid_hold: assert property (@(posedge PS2_clk) disable iff (!rst_n)
        bvalid && !axil_req.bready |=> bvalid);

endmodule

/* design/key_event_fifo.sv */
`timescale 1ns/1ps

module key_event_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                         PS2_clk,
    input  logic                         rst_n,
    input  logic                         push,
    input  ps2_pkg::key_event_t          push_ev,
    input  logic                         pop,
    output ps2_pkg::key_event_t          head,
    output logic                         empty,
    output logic [$clog2(FIFO_DEPTH):0]  count,
    output logic                         overflow,
    input  logic                         clear_overflow
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    ps2_pkg::key_event_t mem [FIFO_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic                full;
    logic                wr_en;
    logic                rd_en;

    assign full  = (count == (PTR_W + 1)'(FIFO_DEPTH));
    assign empty = (count == '0);
    assign wr_en = push && !full;
    assign rd_en = pop && !empty;
    assign head  = mem[rd_ptr];

    always_ff @(posedge PS2_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_ev;
        end
    end

    always_ff @(posedge PS2_clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (PTR_W + 1)'(wr_en) - (PTR_W + 1)'(rd_en);
            if (clear_overflow) begin
                overflow <= 1'b0;
            end
            // A dropped event wins over a clear in the same cycle.
            if (push && full) begin
                overflow <= 1'b1;
            end
        end
    end

    // A write never lands on an entry that has not been read yet.
    a_no_overwrite: assert property (@(posedge PS2_clk) disable iff (!rst_n)
        wr_en |-> (wr_ptr != rd_ptr) || (count == '0));

endmodule

/* design/key_event_decoder.sv */
`timescale 1ns/1ps

module key_event_decoder (
    input  logic                PS2_clk,
    input  logic                rst_n,
    input  logic [7:0]          byte_in,
    input  logic                byte_valid,
    output ps2_pkg::key_event_t ev,
    output logic                ev_valid
);

    logic pend_rel;
    logic pend_ext;
    logic is_break;
    logic is_ext;

    assign is_break = (byte_in == ps2_pkg::KEY_BREAK_PREFIX);
    assign is_ext   = (byte_in == ps2_pkg::KEY_EXT_PREFIX);

    always_ff @(posedge PS2_clk) begin
        if (!rst_n) begin
            pend_rel <= 1'b0;
            pend_ext <= 1'b0;
            ev_valid <= 1'b0;
        end else begin
            ev_valid <= 1'b0;
            if (byte_valid) begin
                if (is_break) begin
                    pend_rel <= 1'b1;
                end else if (is_ext) begin
                    pend_ext <= 1'b1;
                end else begin
                    // Code byte closes the sequence.
                    ev       <= '{released: pend_rel, extended: pend_ext, code: byte_in};
                    ev_valid <= 1'b1;
                    pend_rel <= 1'b0;
                    pend_ext <= 1'b0;
                end
            end
        end
    end

endmodule

/* design/ps2_frame_rx.sv */
`timescale 1ns/1ps

module ps2_frame_rx #(
    parameter int TIMEOUT_CYCLES = 20000
) (
    input  logic             PS2_clk,
    input  logic             rst_n,
    input  logic             enable,
    input  logic             fall_pulse,
    input  logic             data_bit,
    output logic [7:0]       byte_out,
    output logic             byte_valid,
    output ps2_pkg::rx_err_t err,
    output logic             err_valid
);

    localparam int TMR_W = $clog2(TIMEOUT_CYCLES + 1);

    ps2_pkg::rx_state_e state;
    logic [7:0]         shift_reg;
    logic [2:0]         bit_cnt;
    logic               parity_ok;
    logic [TMR_W-1:0]   timer;
    logic               timeout;

    // Keyboard stopped clocking in the middle of a frame.
    assign timeout = (state != ps2_pkg::RX_IDLE) && !fall_pulse &&
                     (timer == TMR_W'(TIMEOUT_CYCLES - 1));

    always_ff @(posedge PS2_clk) begin
        if (!rst_n) begin
            state      <= ps2_pkg::RX_IDLE;
            bit_cnt    <= 3'd0;
            timer      <= '0;
            byte_valid <= 1'b0;
            err_valid  <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            err_valid  <= 1'b0;
            if (!enable) begin
                state <= ps2_pkg::RX_IDLE;
                timer <= '0;
            end else if (timeout) begin
                state     <= ps2_pkg::RX_IDLE;
                timer     <= '0;
                err       <= '{parity: 1'b0, framing: 1'b1};
                err_valid <= 1'b1;
            end else begin
                if (state == ps2_pkg::RX_IDLE || fall_pulse) begin
                    timer <= '0;
                end else begin
                    timer <= timer + 1'b1;
                end
                if (fall_pulse) begin
                    unique case (state)
                        ps2_pkg::RX_IDLE: begin
                            if (!data_bit) begin
                                bit_cnt <= 3'd0;
                                state   <= ps2_pkg::RX_DATA;
                            end else begin
                                err       <= '{parity: 1'b0, framing: 1'b1};
                                err_valid <= 1'b1;
                            end
                        end
                        ps2_pkg::RX_DATA: begin
                            // LSB first.
                            shift_reg <= {data_bit, shift_reg[7:1]};
                            bit_cnt   <= bit_cnt + 3'd1;
                            if (bit_cnt == 3'd7) begin
                                state <= ps2_pkg::RX_PARITY;
                            end
                        end
                        ps2_pkg::RX_PARITY: begin
                            // Odd count of ones over data plus parity.
                            parity_ok <= ^{data_bit, shift_reg};
                            state     <= ps2_pkg::RX_STOP;
                        end
                        ps2_pkg::RX_STOP: begin
                            state <= ps2_pkg::RX_IDLE;
                            if (parity_ok && data_bit) begin
                                byte_out   <= shift_reg;
                                byte_valid <= 1'b1;
                            end else begin
                                err       <= '{parity: !parity_ok, framing: !data_bit};
                                err_valid <= 1'b1;
                            end
                        end
                    endcase
                end
            end
        end
    end

    a_byte_xor_err: assert property (@(posedge PS2_clk) disable iff (!rst_n)
        !(byte_valid && err_valid));

endmodule

/* design/ps2_line_sync.sv */
`timescale 1ns/1ps

module ps2_line_sync (
    input  logic PS2_clk,
    input  logic rst_n,
    input  logic kbd_clk,
    input  logic kbd_data,
    output logic fall_pulse,
    output logic data_bit
);

    logic [1:0] clk_sync;
    logic [1:0] data_sync;
    logic       clk_prev;
    logic       clk_fell;

    // Both lines idle high, so the synchronizers reset to 1.
    always_ff @(posedge PS2_clk) begin
        if (!rst_n) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
        end else begin
            clk_sync  <= {clk_sync[0], kbd_clk};
            data_sync <= {data_sync[0], kbd_data};
        end
    end

    assign clk_fell = clk_prev && !clk_sync[1];

    // Edge register, data is sampled alongside the pulse.
    always_ff @(posedge PS2_clk) begin
        if (!rst_n) begin
            clk_prev   <= 1'b1;
            fall_pulse <= 1'b0;
            data_bit   <= 1'b1;
        end else begin
            clk_prev   <= clk_sync[1];
            fall_pulse <= clk_fell;
            data_bit   <= data_sync[1];
        end
    end

endmodule

/* design/ps2_pkg.sv */
package ps2_pkg;

    localparam int AXIL_ADDR_W = 4;
    localparam int AXIL_DATA_W = 32;

    // Prefix bytes of scan code set 2.
    localparam logic [7:0] KEY_EXT_PREFIX   = 8'hE0;
    localparam logic [7:0] KEY_BREAK_PREFIX = 8'hF0;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_e;

    typedef enum logic [AXIL_ADDR_W-1:0] {
        REG_STATUS = 4'h0,
        REG_DATA   = 4'h4,
        REG_CTRL   = 4'h8,
        REG_ERRCNT = 4'hC
    } reg_addr_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_SLVERR = 2'd2
    } axil_resp_e;

    typedef struct packed {
        logic       released;
        logic       extended;
        logic [7:0] code;
    } key_event_t;

    // Framing covers bad start, bad stop and timeout.
    typedef struct packed {
        logic parity;
        logic framing;
    } rx_err_t;

    typedef struct packed {
        logic [AXIL_ADDR_W-1:0]   awaddr;
        logic                     awvalid;
        logic [AXIL_DATA_W-1:0]   wdata;
        logic [AXIL_DATA_W/8-1:0] wstrb;
        logic                     wvalid;
        logic                     bready;
        logic [AXIL_ADDR_W-1:0]   araddr;
        logic                     arvalid;
        logic                     rready;
    } axil_req_t;

    typedef struct packed {
        logic                   awready;
        logic                   wready;
        axil_resp_e             bresp;
        logic                   bvalid;
        logic                   arready;
        logic [AXIL_DATA_W-1:0] rdata;
        axil_resp_e             rresp;
        logic                   rvalid;
    } axil_rsp_t;

endpackage
